/* Makefile */
VERILATOR ?= verilator
TOP       ?= tinkerCore_tb
FILELIST  ?= tinkerCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Test completed successfully

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check its result"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* axiLiteMaster.sv */
`timescale 1ns/10ps
// AXI4-Lite master that carries one read or one write request at a time
module axiLiteMaster (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            reqValid,
    input  tinkerPkg::busReq_t              req,
    output logic                            reqDone,
    output logic [tinkerPkg::dataWidth-1:0] rdata,
    output logic                            arValid,
    input  logic                            arReady,
    output tinkerPkg::axiAddr_t             ar,
    input  logic                            rValid,
    output logic                            rReady,
    input  tinkerPkg::axiR_t                r,
    output logic                            awValid,
    input  logic                            awReady,
    output tinkerPkg::axiAddr_t             aw,
    output logic                            wValid,
    input  logic                            wReady,
    output tinkerPkg::axiW_t                w,
    input  logic                            bValid,
    output logic                            bReady,
    input  logic [1:0]                      bresp
);
    logic busy;
    logic start;
    logic rDone;
    logic bDone;

    // Idle when no channel flag is up
    assign busy  = arValid || rReady || awValid || wValid || bReady;
    assign start = reqValid && !busy;
    assign rDone = rValid && rReady;
    assign bDone = bValid && bReady;

    // --------------------
    // Channel flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arValid <= 1'b0;
            rReady  <= 1'b0;
            awValid <= 1'b0;
            wValid  <= 1'b0;
            bReady  <= 1'b0;
            reqDone <= 1'b0;
        end else begin
            reqDone <= rDone || bDone;      // Single-cycle pulse

            if (start && !req.write) begin
                arValid <= 1'b1;
                rReady  <= 1'b1;
            end else begin
                if (arReady) arValid <= 1'b0;
                if (rValid)  rReady  <= 1'b0;
            end

            // AW and W drop on their own handshakes
            if (start && req.write) begin
                awValid <= 1'b1;
                wValid  <= 1'b1;
                bReady  <= 1'b1;
            end else begin
                if (awReady) awValid <= 1'b0;
                if (wReady)  wValid  <= 1'b0;
                if (bValid)  bReady  <= 1'b0;
            end
        end
    end

    // --------------------
    // Payloads, held until the handshake
    always_ff @(posedge clk) begin
        if (start) begin
            ar <= '{addr: req.addr, prot: 3'b000};
            aw <= '{addr: req.addr, prot: 3'b000};
            w  <= '{data: req.wdata, strb: '1};
        end
        if (rDone) begin
            rdata <= r.data;
        end
    end

endmodule

/* coreControl.sv */
`timescale 1ns/10ps
// Control unit that holds instruction and pc and sequences fetch through writeback
module coreControl (
    input  logic                            clk,
    input  logic                            reset,
    output tinkerPkg::instr_t               instr,
    output logic [tinkerPkg::dataWidth-1:0] pc,
    input  logic [tinkerPkg::dataWidth-1:0] aluResult,
    input  logic [tinkerPkg::dataWidth-1:0] memAddr,
    input  logic [tinkerPkg::dataWidth-1:0] nextPc,
    input  logic [tinkerPkg::dataWidth-1:0] rsData,
    output logic                            regWrite,
    output logic [tinkerPkg::dataWidth-1:0] wbData,
    output logic                            reqValid,
    output tinkerPkg::busReq_t              req,
    input  logic                            reqDone,
    input  logic [tinkerPkg::dataWidth-1:0] rdata,
    output logic                            hlt
);
    tinkerPkg::state_e               state;
    tinkerPkg::state_e               nextState;
    logic [tinkerPkg::dataWidth-1:0] resultQ;
    logic [tinkerPkg::dataWidth-1:0] memAddrQ;
    logic [tinkerPkg::dataWidth-1:0] nextPcQ;
    logic                            isLoad;
    logic                            isStore;
    logic                            isHalt;
    logic                            writesReg;
    logic                            reqPending;
    logic                            wantReq;
    logic                            pcWrite;

    // --------------------
    // Opcode classes
    assign isLoad  = (instr.opcode == tinkerPkg::opLoad);
    assign isStore = (instr.opcode == tinkerPkg::opStore);
    assign isHalt  = (instr.opcode == tinkerPkg::opHalt) && (instr.lit[3:0] == 4'h0);

    always_comb begin
        case (instr.opcode)
            tinkerPkg::opAnd, tinkerPkg::opOr, tinkerPkg::opXor, tinkerPkg::opNot,
            tinkerPkg::opShftr, tinkerPkg::opShftri, tinkerPkg::opShftl, tinkerPkg::opShftli,
            tinkerPkg::opAdd, tinkerPkg::opAddi, tinkerPkg::opSub, tinkerPkg::opSubi,
            tinkerPkg::opMovReg, tinkerPkg::opMovLit, tinkerPkg::opLoad:
                writesReg = 1'b1;
            default:
                writesReg = 1'b0;   // Branches, store, halt and unknown opcodes
        endcase
    end

    // --------------------
    // Sequencer
    always_comb begin
        nextState = state;
        case (state)
            tinkerPkg::fetch:
                if (reqDone) nextState = tinkerPkg::decode;
            tinkerPkg::decode:
                nextState = isHalt ? tinkerPkg::halted : tinkerPkg::execute;
            tinkerPkg::execute:
                nextState = (isLoad || isStore) ? tinkerPkg::memAccess : tinkerPkg::writeback;
            tinkerPkg::memAccess:
                if (reqDone) nextState = tinkerPkg::writeback;
            tinkerPkg::writeback:
                nextState = tinkerPkg::fetch;
            default:
                nextState = tinkerPkg::halted;  // Stays until reset
        endcase
    end

    // One request per bus state, issued as that state is entered
    assign wantReq = ((nextState == tinkerPkg::fetch) || (nextState == tinkerPkg::memAccess))
                     && !reqPending;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= tinkerPkg::fetch;
            pc         <= tinkerPkg::resetPc;
            reqValid   <= 1'b0;
            reqPending <= 1'b0;
        end else begin
            state    <= nextState;
            reqValid <= wantReq;
            if (reqDone) begin
                reqPending <= 1'b0;
            end else if (wantReq) begin
                reqPending <= 1'b1;
            end
            if (pcWrite) begin
                pc <= nextPcQ;
            end
        end
    end

    // Instruction register and execute latches
    always_ff @(posedge clk) begin
        if ((state == tinkerPkg::fetch) && reqDone) begin
            // Big-endian fetch puts the instruction in the upper word
            instr <= tinkerPkg::instr_t'(rdata[tinkerPkg::dataWidth-1 -: tinkerPkg::instrWidth]);
        end
        if (state == tinkerPkg::execute) begin
            resultQ  <= aluResult;
            memAddrQ <= memAddr;
            nextPcQ  <= nextPc;
        end
    end

    // --------------------
    // Bus request and writeback
    always_comb begin
        req.write = (state == tinkerPkg::memAccess) && isStore;
        req.addr  = (state == tinkerPkg::memAccess) ? memAddrQ[tinkerPkg::addrWidth-1:0]
                                                    : pc[tinkerPkg::addrWidth-1:0];
        req.wdata = rsData;     // Store source register
    end

    assign pcWrite  = (state == tinkerPkg::writeback);
    assign regWrite = pcWrite && writesReg;
    assign wbData   = isLoad ? rdata : resultQ;   // Master holds load data until next request
    assign hlt      = (state == tinkerPkg::halted);

endmodule

/* intAlu.sv */
`timescale 1ns/10ps
// Integer ALU giving the result, effective address and next pc of one instruction
module intAlu (
    input  tinkerPkg::instr_t               instr,
    input  logic [tinkerPkg::dataWidth-1:0] pc,
    input  logic [tinkerPkg::dataWidth-1:0] rsData,
    input  logic [tinkerPkg::dataWidth-1:0] rtData,
    input  logic [tinkerPkg::dataWidth-1:0] rdData,
    output logic [tinkerPkg::dataWidth-1:0] result,
    output logic [tinkerPkg::dataWidth-1:0] memAddr,
    output logic [tinkerPkg::dataWidth-1:0] nextPc
);
    logic [tinkerPkg::dataWidth-1:0] litSext;
    logic [tinkerPkg::dataWidth-1:0] litZext;
    logic [tinkerPkg::dataWidth-1:0] pcPlus4;

    // --------------------
    // Literal forms
    assign litSext = {{(tinkerPkg::dataWidth - tinkerPkg::litWidth){instr.lit[tinkerPkg::litWidth-1]}},
                      instr.lit};
    assign litZext = {{(tinkerPkg::dataWidth - tinkerPkg::litWidth){1'b0}}, instr.lit};
    assign pcPlus4 = pc + tinkerPkg::instrBytes;

    // --------------------
    // Result
    always_comb begin
        case (instr.opcode)
            tinkerPkg::opAnd:    result = rsData & rtData;
            tinkerPkg::opOr:     result = rsData | rtData;
            tinkerPkg::opXor:    result = rsData ^ rtData;
            tinkerPkg::opNot:    result = ~rsData;          // rt unused
            tinkerPkg::opShftr:  result = rsData >> rtData;
            tinkerPkg::opShftri: result = rdData >> litZext;
            tinkerPkg::opShftl:  result = rsData << rtData;
            tinkerPkg::opShftli: result = rdData << litZext;
            tinkerPkg::opAdd:    result = rsData + rtData;
            tinkerPkg::opAddi:   result = rdData + litSext;
            tinkerPkg::opSub:    result = rsData - rtData;
            tinkerPkg::opSubi:   result = rdData - litZext;
            tinkerPkg::opMovReg: result = rsData;
            tinkerPkg::opMovLit: result = litZext;
            default:             result = '0;
        endcase
    end

    // Load uses rs as base, store uses rd
    assign memAddr = (instr.opcode == tinkerPkg::opStore) ? rdData + litSext
                                                          : rsData + litSext;

    // --------------------
    // Next pc
    always_comb begin
        case (instr.opcode)
            tinkerPkg::opBr:     nextPc = rdData;
            tinkerPkg::opBrr:    nextPc = pc + rdData;
            tinkerPkg::opBrrLit: nextPc = pc + litSext;
            tinkerPkg::opBrnz:   nextPc = (rsData != '0) ? rdData : pcPlus4;
            default:             nextPc = pcPlus4;
        endcase
    end

endmodule

/* regFile.sv */
`timescale 1ns/10ps
// Register file of 32 64-bit registers with combinational reads and one write port
module regFile (
    input  logic                            clk,
    input  logic                            reset,
    input  tinkerPkg::instr_t               instr,
    input  logic                            regWrite,
    input  logic [tinkerPkg::dataWidth-1:0] wbData,
    output logic [tinkerPkg::dataWidth-1:0] rsData,
    output logic [tinkerPkg::dataWidth-1:0] rtData,
    output logic [tinkerPkg::dataWidth-1:0] rdData
);
    logic [tinkerPkg::dataWidth-1:0] regs [tinkerPkg::numRegs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < tinkerPkg::numRegs - 1; i++) begin
                regs[i] <= '0;
            end
            regs[tinkerPkg::numRegs-1] <= tinkerPkg::resetSp;  // Stack pointer
        end else if (regWrite) begin
            regs[instr.rd] <= wbData;
        end
    end

    // Read ports
    assign rsData = regs[instr.rs];
    assign rtData = regs[instr.rt];
    assign rdData = regs[instr.rd];     // Immediates, store base and branch targets

endmodule

/* tbAxiMem.sv */
// Testbench AXI4-Lite memory, byte addressed and big-endian, with stalls on each channel
`timescale 1ns/10ps
module tbAxiMem (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          stall,      // AR, R, AW, W, B
    input  logic                arValid,
    output logic                arReady,
    input  tinkerPkg::axiAddr_t ar,
    output logic                rValid,
    input  logic                rReady,
    output tinkerPkg::axiR_t    r,
    input  logic                awValid,
    output logic                awReady,
    input  tinkerPkg::axiAddr_t aw,
    input  logic                wValid,
    output logic                wReady,
    input  tinkerPkg::axiW_t    w,
    output logic                bValid,
    input  logic                bReady,
    output logic [1:0]          bresp
);
    logic [7:0]  bytes [int unsigned];
    logic [31:0] rAddr;
    logic [31:0] wAddr;
    logic [63:0] wData;
    logic        rPend;
    logic        awGot;
    logic        wGot;

    task automatic clearMem();
        bytes.delete();
    endtask

    // n bytes, most significant first
    task automatic putBytes(input logic [31:0] addr, input logic [63:0] data, input int n);
        for (int i = 0; i < n; i++) begin
            bytes[addr + i] = data[8 * (n - 1 - i) +: 8];
        end
    endtask

    // Unwritten bytes read back a pattern of the whole address
    function automatic logic [63:0] readWord(input logic [31:0] addr);
        logic [63:0] data;
        logic [31:0] a;
        for (int i = 0; i < 8; i++) begin
            a = addr + i;
            data[8 * (7 - i) +: 8] = bytes.exists(a) ? bytes[a]
                                                     : (a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0]);
        end
        return data;
    endfunction

    // --------------------
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            arReady <= 1'b0;
            rValid  <= 1'b0;
            r       <= '0;
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b0;
            bresp   <= 2'b00;
            rPend   <= 1'b0;
            awGot   <= 1'b0;
            wGot    <= 1'b0;
            rAddr   <= '0;
            wAddr   <= '0;
            wData   <= '0;
        end else begin
            arReady <= !stall[0];
            awReady <= !stall[2];
            wReady  <= !stall[3];
            if (arValid && arReady) begin
                rAddr <= ar.addr;
                rPend <= 1'b1;
            end
            if (rValid && rReady) begin
                rValid <= 1'b0;
                rPend  <= 1'b0;
            end else if (rPend && !rValid && !stall[1]) begin
                rValid <= 1'b1;
                r      <= '{data: readWord(rAddr), resp: 2'b00};
            end
            if (awValid && awReady) begin
                wAddr <= aw.addr;
                awGot <= 1'b1;
            end
            if (wValid && wReady) begin
                wData <= w.data;
                wGot  <= 1'b1;
            end
            // Write lands once both halves are in
            if (bValid && bReady) begin
                bValid <= 1'b0;
                awGot  <= 1'b0;
                wGot   <= 1'b0;
            end else if (awGot && wGot && !bValid && !stall[4]) begin
                putBytes(wAddr, wData, 8);
                bValid <= 1'b1;
            end
        end
    end

endmodule

/* tinkerCore.f */
tinkerPkg.sv
regFile.sv
intAlu.sv
axiLiteMaster.sv
coreControl.sv
tinkerCore.sv
tbAxiMem.sv
tinkerCore_tb.sv

/* tinkerCore.sv */
`timescale 1ns/10ps
// Tinker core top joining control, register file, ALU and the AXI4-Lite master
module tinkerCore (
    input  logic                clk,
    input  logic                reset,
    output logic                hlt,
    // AXI4-Lite master
    output logic                arValid,
    input  logic                arReady,
    output tinkerPkg::axiAddr_t ar,
    input  logic                rValid,
    output logic                rReady,
    input  tinkerPkg::axiR_t    r,
    output logic                awValid,
    input  logic                awReady,
    output tinkerPkg::axiAddr_t aw,
    output logic                wValid,
    input  logic                wReady,
    output tinkerPkg::axiW_t    w,
    input  logic                bValid,
    output logic                bReady,
    input  logic [1:0]          bresp
);
    tinkerPkg::instr_t               instr;
    tinkerPkg::busReq_t              req;
    logic [tinkerPkg::dataWidth-1:0] pc;
    logic [tinkerPkg::dataWidth-1:0] aluResult;
    logic [tinkerPkg::dataWidth-1:0] memAddr;
    logic [tinkerPkg::dataWidth-1:0] nextPc;
    logic [tinkerPkg::dataWidth-1:0] rsData;
    logic [tinkerPkg::dataWidth-1:0] rtData;
    logic [tinkerPkg::dataWidth-1:0] rdData;
    logic [tinkerPkg::dataWidth-1:0] wbData;
    logic [tinkerPkg::dataWidth-1:0] rdata;
    logic                            regWrite;
    logic                            reqValid;
    logic                            reqDone;

    coreControl control (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .pc        (pc),
        .aluResult (aluResult),
        .memAddr   (memAddr),
        .nextPc    (nextPc),
        .rsData    (rsData),
        .regWrite  (regWrite),
        .wbData    (wbData),
        .reqValid  (reqValid),
        .req       (req),
        .reqDone   (reqDone),
        .rdata     (rdata),
        .hlt       (hlt)
    );

    regFile registers (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .regWrite (regWrite),
        .wbData   (wbData),
        .rsData   (rsData),
        .rtData   (rtData),
        .rdData   (rdData)
    );

    intAlu alu (
        .instr   (instr),
        .pc      (pc),
        .rsData  (rsData),
        .rtData  (rtData),
        .rdData  (rdData),
        .result  (aluResult),
        .memAddr (memAddr),
        .nextPc  (nextPc)
    );

    axiLiteMaster busMaster (
        .clk      (clk),
        .reset    (reset),
        .reqValid (reqValid),
        .req      (req),
        .reqDone  (reqDone),
        .rdata    (rdata),
        .arValid  (arValid),
        .arReady  (arReady),
        .ar       (ar),
        .rValid   (rValid),
        .rReady   (rReady),
        .r        (r),
        .awValid  (awValid),
        .awReady  (awReady),
        .aw       (aw),
        .wValid   (wValid),
        .wReady   (wReady),
        .w        (w),
        .bValid   (bValid),
        .bReady   (bReady),
        .bresp    (bresp)
    );

endmodule

/* tinkerCore_tb.sv */
// Testbench for the tinker core running directed programs from an AXI4-Lite memory model
`timescale 1ns/10ps
module tinkerCore_tb;
    localparam int          hltTimeout  = 5000;
    localparam int          quietCycles = 30;
    localparam logic [63:0] dataBase    = 64'h800;   // Held in r10 by every program

    logic                clk;
    logic                reset;
    logic                hlt;
    logic                arValid;
    logic                arReady;
    tinkerPkg::axiAddr_t ar;
    logic                rValid;
    logic                rReady;
    tinkerPkg::axiR_t    r;
    logic                awValid;
    logic                awReady;
    tinkerPkg::axiAddr_t aw;
    logic                wValid;
    logic                wReady;
    tinkerPkg::axiW_t    w;
    logic                bValid;
    logic                bReady;
    logic [1:0]          bresp;
    logic [4:0]          stall = '0;
    logic                randomDelay;
    logic [15:0]         lfsrState = 16'd55;

    logic [31:0] prog [$];
    logic [63:0] expAddr [$];
    logic [63:0] expData [$];
    logic [63:0] gotAddr [$];
    logic [63:0] gotData [$];
    logic [63:0] pendAddr;
    logic [63:0] pendData;
    logic        haveAddr;
    logic        haveData;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          errorsAtStart;

    tinkerCore dut (.*);
    tbAxiMem mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrBit();
        logic feedback;
        feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    always @(posedge clk) begin : stallGen
        logic [4:0] bits;
        bits = '0;
        if (randomDelay) begin
            for (int i = 0; i < 5; i++) begin
                bits[i] = lfsrBit();
            end
        end
        stall <= bits;
    end

    // Completed writes whose address and data may arrive on different cycles
    always @(posedge clk) begin : storeMonitor
        if (reset) begin
            haveAddr = 1'b0;
            haveData = 1'b0;
        end else begin
            if (arValid && arReady) begin
                checkValue("ar.prot", 64'h0, 64'(ar.prot));
            end
            if (awValid && awReady) begin
                checkValue("aw.prot", 64'h0, 64'(aw.prot));
                pendAddr = {32'h0, aw.addr};
                haveAddr = 1'b1;
            end
            if (wValid && wReady) begin
                checkValue("w.strb", 64'hff, 64'(w.strb));
                pendData = w.data;
                haveData = 1'b1;
            end
            if (haveAddr && haveData) begin
                gotAddr.push_back(pendAddr);
                gotData.push_back(pendData);
                haveAddr = 1'b0;
                haveData = 1'b0;
            end
        end
    end

    // --------------------
    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic emit(input logic [4:0] op, input int rd, input int rs, input int rt,
                        input int lit);
        prog.push_back({op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]});
    endtask

    task automatic expectStore(input logic [63:0] addr, input logic [63:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // Store of src to r10 plus off
    task automatic storeExpect(input int src, input int off, input logic [63:0] value);
        emit(tinkerPkg::opStore, 10, src, 0, off);
        expectStore(dataBase + 64'(off), value);
    endtask

    task automatic startTest();
        @(posedge clk);
        reset <= 1'b1;
        mem.clearMem();
        prog.delete();
        expAddr.delete();
        expData.delete();
        gotAddr.delete();
        gotData.delete();
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest(input string name);
        int   cycles;
        logic dropped;
        logic busy;
        for (int i = 0; i < prog.size(); i++) begin
            mem.putBytes(32'h2000 + 32'(4 * i), {32'h0, prog[i]}, 4);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!hlt && cycles < hltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!hlt) begin
            $display("%s: hlt did not rise within %0d cycles", name, hltTimeout);
            errorCount++;
        end else begin
            dropped = 1'b0;
            busy    = 1'b0;
            repeat (quietCycles) begin
                @(negedge clk);
                if (!hlt) dropped = 1'b1;
                if (arValid || awValid || wValid) busy = 1'b1;
            end
            if (dropped) begin
                $display("%s: hlt fell while the core was halted", name);
                errorCount++;
            end
            if (busy) begin
                $display("%s: bus request seen after halt", name);
                errorCount++;
            end
        end
        checkValue("store count", 64'(expAddr.size()), 64'(gotAddr.size()));
        for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
            checkValue("aw.addr", expAddr[i], gotAddr[i]);
            checkValue("w.data", expData[i], gotData[i]);
        end
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("%s: passed", name);
        end else begin
            failedTests++;
            $display("%s: failed", name);
        end
    endtask

    // --------------------
    task automatic buildArith();
        emit(tinkerPkg::opMovLit, 10, 0, 0, 'h800);
        emit(tinkerPkg::opMovLit, 1, 0, 0, 100);
        emit(tinkerPkg::opMovLit, 2, 0, 0, 'h7ff);
        emit(tinkerPkg::opAdd, 3, 1, 2, 0);
        emit(tinkerPkg::opSub, 4, 1, 2, 0);
        emit(tinkerPkg::opMovLit, 5, 0, 0, 10);
        emit(tinkerPkg::opAddi, 5, 0, 0, -3);       // Sign-extended
        emit(tinkerPkg::opMovLit, 6, 0, 0, 50);
        emit(tinkerPkg::opSubi, 6, 0, 0, 'hfff);    // Zero-extended
        storeExpect(3, 0, 64'd100 + 64'd2047);
        storeExpect(4, 8, 64'd100 - 64'd2047);
        storeExpect(5, 16, 64'd10 - 64'd3);
        storeExpect(6, 24, 64'd50 - 64'd4095);
        emit(tinkerPkg::opHalt, 0, 0, 0, 0);
    endtask

    task automatic arithmeticTest();
        startTest();
        buildArith();
        finishTest("arithmetic");
    endtask

    task automatic logicShiftTest();
        startTest();
        emit(tinkerPkg::opMovLit, 10, 0, 0, 'h800);
        emit(tinkerPkg::opMovLit, 1, 0, 0, 'hf0f);
        emit(tinkerPkg::opMovLit, 2, 0, 0, 'h0ff);
        emit(tinkerPkg::opAnd, 3, 1, 2, 0);
        emit(tinkerPkg::opOr, 4, 1, 2, 0);
        emit(tinkerPkg::opXor, 5, 1, 2, 0);
        emit(tinkerPkg::opNot, 6, 1, 0, 0);
        emit(tinkerPkg::opMovLit, 7, 0, 0, 4);
        emit(tinkerPkg::opShftr, 8, 1, 7, 0);
        emit(tinkerPkg::opShftl, 9, 1, 7, 0);
        emit(tinkerPkg::opMovLit, 11, 0, 0, 'habc);
        emit(tinkerPkg::opShftri, 11, 0, 0, 8);
        emit(tinkerPkg::opMovLit, 12, 0, 0, 'h123);
        emit(tinkerPkg::opShftli, 12, 0, 0, 52);
        storeExpect(3, 0, 64'hf0f & 64'h0ff);
        storeExpect(4, 8, 64'hf0f | 64'h0ff);
        storeExpect(5, 16, 64'hf0f ^ 64'h0ff);
        storeExpect(6, 24, ~64'hf0f);
        storeExpect(8, 32, 64'hf0f >> 4);
        storeExpect(9, 40, 64'hf0f << 4);
        storeExpect(11, 48, 64'habc >> 8);
        storeExpect(12, 56, 64'h123 << 52);
        emit(tinkerPkg::opHalt, 0, 0, 0, 0);
        finishTest("logic/shift");
    endtask

    task automatic loadStoreTest();
        startTest();
        emit(tinkerPkg::opMovLit, 10, 0, 0, 'h800);
        emit(tinkerPkg::opMovLit, 1, 0, 0, 'h5a5);
        storeExpect(1, 0, 64'h5a5);
        emit(tinkerPkg::opLoad, 2, 10, 0, 0);
        storeExpect(2, 8, 64'h5a5);
        emit(tinkerPkg::opLoad, 3, 31, 0, -16);     // Just below the reset stack pointer
        storeExpect(3, 16, 64'h1122_3344_5566_7788);
        storeExpect(31, 24, 64'h8_0000);
        emit(tinkerPkg::opHalt, 0, 0, 0, 0);
        mem.putBytes(32'h8_0000 - 32'd16, 64'h1122_3344_5566_7788, 8);
        finishTest("load/store");
    endtask

    // Marker stores at offsets 16, 40, 56, 64 and 80 lie on the taken path
    task automatic branchTest();
        startTest();
        emit(tinkerPkg::opMovLit, 10, 0, 0, 'h800);
        emit(tinkerPkg::opMovLit, 20, 0, 0, 'h77);
        emit(tinkerPkg::opMovLit, 2, 0, 0, 'h200);
        emit(tinkerPkg::opShftli, 2, 0, 0, 4);
        emit(tinkerPkg::opAddi, 2, 0, 0, 32);       // Absolute target of instruction 8
        emit(tinkerPkg::opBr, 2, 0, 0, 0);
        emit(tinkerPkg::opStore, 10, 20, 0, 0);
        emit(tinkerPkg::opStore, 10, 20, 0, 8);
        emit(tinkerPkg::opStore, 10, 20, 0, 16);
        emit(tinkerPkg::opMovLit, 3, 0, 0, 12);
        emit(tinkerPkg::opBrr, 3, 0, 0, 0);         // Skips two
        emit(tinkerPkg::opStore, 10, 20, 0, 24);
        emit(tinkerPkg::opStore, 10, 20, 0, 32);
        emit(tinkerPkg::opStore, 10, 20, 0, 40);
        emit(tinkerPkg::opBrrLit, 0, 0, 0, 8);
        emit(tinkerPkg::opStore, 10, 20, 0, 48);
        emit(tinkerPkg::opStore, 10, 20, 0, 56);
        emit(tinkerPkg::opBrnz, 2, 0, 0, 0);        // r0 is zero so it falls through
        emit(tinkerPkg::opStore, 10, 20, 0, 64);
        emit(tinkerPkg::opMovLit, 4, 0, 0, 1);
        emit(tinkerPkg::opMovLit, 5, 0, 0, 'h200);
        emit(tinkerPkg::opShftli, 5, 0, 0, 4);
        emit(tinkerPkg::opAddi, 5, 0, 0, 100);      // Instruction 25
        emit(tinkerPkg::opBrnz, 5, 4, 0, 0);
        emit(tinkerPkg::opStore, 10, 20, 0, 72);
        emit(tinkerPkg::opStore, 10, 20, 0, 80);
        emit(tinkerPkg::opHalt, 0, 0, 0, 0);
        expectStore(dataBase + 64'd16, 64'h77);
        expectStore(dataBase + 64'd40, 64'h77);
        expectStore(dataBase + 64'd56, 64'h77);
        expectStore(dataBase + 64'd64, 64'h77);
        expectStore(dataBase + 64'd80, 64'h77);
        finishTest("branch");
    endtask

    task automatic haltTest();
        startTest();
        emit(tinkerPkg::opMovLit, 10, 0, 0, 'h800);
        emit(tinkerPkg::opMovLit, 1, 0, 0, 5);
        storeExpect(1, 0, 64'd5);
        emit(tinkerPkg::opHalt, 0, 0, 0, 0);
        emit(tinkerPkg::opStore, 10, 1, 0, 8);      // Must never run
        finishTest("halt");
    endtask

    task automatic backPressureTest();
        @(posedge clk);
        randomDelay <= 1'b1;
        startTest();
        buildArith();
        finishTest("back-pressure");
        randomDelay <= 1'b0;
    endtask

    // --------------------
    initial begin
        reset       = 1'b1;
        randomDelay = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        arithmeticTest();
        logicShiftTest();
        loadStoreTest();
        branchTest();
        haltTest();
        backPressureTest();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tinkerPkg.sv */
// Tinker core package with widths, opcodes, reset values, FSM states and bus structs
package tinkerPkg;

    // --------------------
    // Widths and sizes
    localparam int addrWidth    = 32;
    localparam int dataWidth    = 64;
    localparam int instrWidth   = 32;
    localparam int litWidth     = 12;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;
    localparam int strbWidth    = dataWidth / 8;   // One strobe per byte

    // Reset values and pc step
    localparam logic [dataWidth-1:0] resetPc    = 64'h2000;
    localparam logic [dataWidth-1:0] resetSp    = 64'h8_0000;  // r31, top of memory
    localparam logic [dataWidth-1:0] instrBytes = 64'd4;

    // --------------------
    // Kept opcodes, reference encodings
    typedef enum logic [4:0] {
        opAnd    = 5'h00,
        opOr     = 5'h01,
        opXor    = 5'h02,
        opNot    = 5'h03,
        opShftr  = 5'h04,
        opShftri = 5'h05,
        opShftl  = 5'h06,
        opShftli = 5'h07,
        opBr     = 5'h08,
        opBrr    = 5'h09,   // brr rd
        opBrrLit = 5'h0a,   // brr L
        opBrnz   = 5'h0b,
        opHalt   = 5'h0f,
        opLoad   = 5'h10,   // mov rd, (rs)(L)
        opMovReg = 5'h11,
        opMovLit = 5'h12,
        opStore  = 5'h13,   // mov (rd)(L), rs
        opAdd    = 5'h18,
        opAddi   = 5'h19,
        opSub    = 5'h1a,
        opSubi   = 5'h1b
    } opcode_e;

    // Sequencer states
    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        memAccess,
        writeback,
        halted
    } state_e;

    // --------------------
    // Instruction fields, opcode in the top bits
    typedef struct packed {
        opcode_e                 opcode;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [litWidth-1:0]     lit;
    } instr_t;

    // AR and AW payload
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [2:0]           prot;
    } axiAddr_t;

    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic [strbWidth-1:0] strb;
    } axiW_t;

    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic [1:0]           resp;
    } axiR_t;

    // Request from the control unit to the bus master
    typedef struct packed {
        logic                 write;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } busReq_t;

endpackage
